// ==== rtl/flash_pkg.sv ====
package flash_pkg;

	// ----------------------------------------------------------
	// word and request sizes
	// ----------------------------------------------------------
	localparam int WORD_BITS     = 8;
	localparam int ADDR_WORDS    = 2;
	localparam int LEN_BITS      = 8;
	// bit counter inside a shifter
	localparam int BIT_CNT_BITS  = $clog2(WORD_BITS);
	// address word counter in the sequencer
	localparam int ADDR_CNT_BITS = $clog2(ADDR_WORDS + 1);

	typedef logic [WORD_BITS - 1 : 0]              flash_word_t;
	typedef logic [WORD_BITS * ADDR_WORDS - 1 : 0] flash_addr_t;
	typedef logic [LEN_BITS - 1 : 0]               flash_len_t;

	// ----------------------------------------------------------
	// flash command codes
	// ----------------------------------------------------------
	localparam flash_word_t CMD_WRITE_STATUS  = 8'h01;
	localparam flash_word_t CMD_WRITE         = 8'h02;
	localparam flash_word_t CMD_READ          = 8'h03;
	localparam flash_word_t CMD_WRITE_DISABLE = 8'h04;
	localparam flash_word_t CMD_READ_STATUS   = 8'h05;
	localparam flash_word_t CMD_WRITE_ENABLE  = 8'h06;

	// power-up phases, in serial_clk_raw cycles
	localparam int WAIT_INIT        = 16;
	localparam int WAIT_RESET       = 4;
	localparam int WAIT_AFTER_RESET = 8;
	// longest wait sets the counter width
	localparam int WAIT_BITS        = $clog2(WAIT_INIT + 1);

	typedef enum logic [3 : 0] {
		S_INIT, S_RESET, S_AFTER_RESET,
		S_IDLE, S_END,
		S_CMD, S_ADDR,
		S_STATUS_RD, S_STATUS_WR,
		S_RD_DATA, S_WR_DATA
	} flash_state_t;

	// status bits 7, 1, 0 survive, block protect bits 6..2 cleared
	localparam flash_word_t STATUS_KEEP_MASK = 8'b1000_0011;

	function automatic flash_word_t unlock_status(input flash_word_t status);
		return status & STATUS_KEEP_MASK;
	endfunction

endpackage

// ==== rtl/flash_shift_if.sv ====
`timescale 1ns/1ps

interface flash_shift_if
	import flash_pkg::*;
();
	// from the sequencer
	logic        start;
	flash_word_t word;

	// from the shifter
	logic        busy;
	logic        done;
	// received word, or echo of the sent word
	flash_word_t result;

	modport sequencer (output start, output word, input busy, input done, input result);

	modport out_shifter (input start, input word, output busy, output done, output result);

	modport in_shifter (input start, input word, output busy, output done, output result);

endinterface

// ==== rtl/flash_shift_out.sv ====
`timescale 1ns/1ps

module flash_shift_out
	import flash_pkg::*;
(
	input logic serial_clk_raw,
	input logic in_rst,
	flash_shift_if.out_shifter shift,
	output logic mosi
);

	logic busy_q;
	logic done_q;
	logic [BIT_CNT_BITS - 1 : 0] bit_cnt;
	flash_word_t sreg;
	// copy of the word in flight
	flash_word_t word_q;

	assign shift.busy   = busy_q;
	assign shift.done   = done_q;
	assign shift.result = word_q;

	// ----------------------------------------------------------
	// control, rising edge
	// ----------------------------------------------------------
	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (shift.start) begin
				busy_q  <= 1'b1;
				bit_cnt <= '0;
			end else if (busy_q) begin
				bit_cnt <= BIT_CNT_BITS'(bit_cnt + 1'b1);
				// last bit went out on the previous falling edge
				if (bit_cnt == BIT_CNT_BITS'(WORD_BITS - 1)) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// shift register, msb first
	always_ff @(posedge serial_clk_raw) begin
		if (shift.start) begin
			sreg   <= shift.word;
			word_q <= shift.word;
		end else if (busy_q) begin
			sreg <= sreg << 1;
		end
	end

	// bit presented on falling edge, flash samples on the next rising one
	always_ff @(negedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			mosi <= 1'b0;
		end else begin
			mosi <= busy_q ? sreg[WORD_BITS - 1] : 1'b0;
		end
	end

	// the sequencer must wait for the word to finish
	a_no_start_busy: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		shift.start |-> !shift.busy)
		else $error("flash_shift_out: start while busy");

endmodule

// ==== rtl/flash_shift_in.sv ====
`timescale 1ns/1ps

module flash_shift_in
	import flash_pkg::*;
(
	input logic serial_clk_raw,
	input logic in_rst,
	flash_shift_if.in_shifter shift,
	input logic miso
);

	logic busy_q;
	logic done_q;
	logic [BIT_CNT_BITS - 1 : 0] bit_cnt;
	flash_word_t sreg;

	assign shift.busy   = busy_q;
	assign shift.done   = done_q;
	// valid together with done
	assign shift.result = sreg;

	// ----------------------------------------------------------
	// control
	// ----------------------------------------------------------
	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (shift.start) begin
				busy_q  <= 1'b1;
				bit_cnt <= '0;
			end else if (busy_q) begin
				bit_cnt <= BIT_CNT_BITS'(bit_cnt + 1'b1);
				if (bit_cnt == BIT_CNT_BITS'(WORD_BITS - 1)) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// sample miso on rising edges, msb arrives first
	always_ff @(posedge serial_clk_raw) begin
		if (shift.start) begin
			// preload, fully replaced after one word
			sreg <= shift.word;
		end else if (busy_q) begin
			sreg <= {sreg[WORD_BITS - 2 : 0], miso};
		end
	end

	a_done_after_busy: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		shift.done |-> $past(shift.busy))
		else $error("flash_shift_in: done without a word in progress");

endmodule

// ==== rtl/flash_cmd_seq.sv ====
`timescale 1ns/1ps

module flash_cmd_seq
	import flash_pkg::*;
(
	input  logic        serial_clk_raw,
	input  logic        in_rst,

	input  logic        req_valid,
	output logic        req_ready,
	input  logic        req_read,
	input  flash_addr_t req_addr,
	input  flash_len_t  req_len,

	input  logic        wr_valid,
	output logic        wr_ready,
	input  flash_word_t wr_data,

	output logic        rd_valid,
	input  logic        rd_ready,
	output flash_word_t rd_data,

	flash_shift_if.sequencer tx,
	flash_shift_if.sequencer rx,

	output logic        flash_rst_n,
	output logic        flash_clk_en,
	output logic        flash_cs_n,
	output logic        flash_wp_n
);

	flash_state_t state;
	flash_state_t init_next;
	logic [WAIT_BITS - 1 : 0] wait_cnt;
	logic [WAIT_BITS - 1 : 0] wait_last;

	// request registers
	flash_addr_t addr_sh;
	logic [ADDR_CNT_BITS - 1 : 0] addr_left;
	flash_len_t len_left;
	logic rd_q;

	// set until the status register has been unlocked once
	logic protect;
	flash_word_t status_q;

	logic tx_start_q;
	logic rx_start_q;
	flash_word_t tx_word_q;
	logic wp_low;

	assign tx.start = tx_start_q;
	assign tx.word  = tx_word_q;
	assign rx.start = rx_start_q;
	assign rx.word  = '0;

	assign req_ready    = (state == S_IDLE);
	assign flash_rst_n  = (state != S_RESET);
	// flash clock only runs while a word is on the bus
	assign flash_clk_en = tx.busy | rx.busy;
	assign flash_wp_n   = ~wp_low;

	// ----------------------------------------------------------
	// power-up wait lengths
	// ----------------------------------------------------------
	always_comb begin
		case (state)
			S_INIT: begin
				wait_last = WAIT_BITS'(WAIT_INIT - 1);
				init_next = S_RESET;
			end
			S_RESET: begin
				wait_last = WAIT_BITS'(WAIT_RESET - 1);
				init_next = S_AFTER_RESET;
			end
			default: begin
				wait_last = WAIT_BITS'(WAIT_AFTER_RESET - 1);
				init_next = S_IDLE;
			end
		endcase
	end

	// write protect released for status write and data write
	always_comb begin
		case (state)
			S_CMD:                  wp_low = (tx_word_q == CMD_WRITE_STATUS) ||
			                                 (tx_word_q == CMD_WRITE);
			S_ADDR:                 wp_low = !rd_q;
			S_STATUS_WR, S_WR_DATA: wp_low = 1'b1;
			default:                wp_low = 1'b0;
		endcase
	end

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------
	always_ff @(posedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			state      <= S_INIT;
			wait_cnt   <= '0;
			addr_sh    <= '0;
			addr_left  <= '0;
			len_left   <= '0;
			rd_q       <= 1'b0;
			protect    <= 1'b1;
			status_q   <= '0;
			tx_start_q <= 1'b0;
			rx_start_q <= 1'b0;
			tx_word_q  <= '0;
			flash_cs_n <= 1'b1;
			wr_ready   <= 1'b0;
			rd_valid   <= 1'b0;
			rd_data    <= '0;
		end else begin
			// start is a single-cycle pulse
			tx_start_q <= 1'b0;
			rx_start_q <= 1'b0;

			case (state)
				S_INIT, S_RESET, S_AFTER_RESET: begin
					if (wait_cnt == wait_last) begin
						wait_cnt <= '0;
						state    <= init_next;
					end else begin
						wait_cnt <= WAIT_BITS'(wait_cnt + 1'b1);
					end
				end

				// accept a request, reads go straight to the command
				S_IDLE: begin
					if (req_valid) begin
						rd_q       <= req_read;
						addr_sh    <= req_addr;
						len_left   <= req_len;
						flash_cs_n <= 1'b0;
						tx_start_q <= 1'b1;
						tx_word_q  <= req_read ? CMD_READ : CMD_WRITE_ENABLE;
						state      <= S_CMD;
					end
				end

				// chip deselected between chained commands
				S_END: begin
					flash_cs_n <= 1'b0;
					tx_start_q <= 1'b1;
					state      <= S_CMD;
				end

				// next step depends on the command just sent
				S_CMD: begin
					if (tx.done) begin
						case (tx.result)
							CMD_WRITE_ENABLE, CMD_WRITE_DISABLE: begin
								flash_cs_n <= 1'b1;
								tx_word_q  <= protect ? CMD_READ_STATUS : CMD_WRITE;
								state      <= S_END;
							end
							CMD_READ_STATUS: begin
								rx_start_q <= 1'b1;
								state      <= S_STATUS_RD;
							end
							CMD_WRITE_STATUS: begin
								tx_start_q <= 1'b1;
								tx_word_q  <= unlock_status(status_q);
								state      <= S_STATUS_WR;
							end
							default: begin
								// read or write, address follows, high word first
								tx_start_q <= 1'b1;
								tx_word_q  <= addr_sh[$bits(flash_addr_t) - 1 -: WORD_BITS];
								addr_sh    <= addr_sh << WORD_BITS;
								addr_left  <= ADDR_CNT_BITS'(ADDR_WORDS - 1);
								state      <= S_ADDR;
							end
						endcase
					end
				end

				S_STATUS_RD: begin
					if (rx.done) begin
						status_q   <= rx.result;
						flash_cs_n <= 1'b1;
						tx_word_q  <= CMD_WRITE_STATUS;
						state      <= S_END;
					end
				end

				// after the unlock a fresh write enable is needed
				S_STATUS_WR: begin
					if (tx.done) begin
						protect    <= 1'b0;
						flash_cs_n <= 1'b1;
						tx_word_q  <= CMD_WRITE_ENABLE;
						state      <= S_END;
					end
				end

				S_ADDR: begin
					if (tx.done) begin
						if (addr_left != '0) begin
							tx_start_q <= 1'b1;
							tx_word_q  <= addr_sh[$bits(flash_addr_t) - 1 -: WORD_BITS];
							addr_sh    <= addr_sh << WORD_BITS;
							addr_left  <= ADDR_CNT_BITS'(addr_left - 1'b1);
						end else if (len_left == '0) begin
							// empty burst
							flash_cs_n <= 1'b1;
							state      <= S_IDLE;
						end else if (rd_q) begin
							rx_start_q <= 1'b1;
							state      <= S_RD_DATA;
						end else begin
							wr_ready <= 1'b1;
							state    <= S_WR_DATA;
						end
					end
				end

				// one word at a time, next starts only after the host took it
				S_RD_DATA: begin
					if (rx.done) begin
						rd_data  <= rx.result;
						rd_valid <= 1'b1;
						len_left <= LEN_BITS'(len_left - 1'b1);
					end
					if (rd_valid && rd_ready) begin
						rd_valid <= 1'b0;
						if (len_left != '0) begin
							rx_start_q <= 1'b1;
						end else begin
							flash_cs_n <= 1'b1;
							state      <= S_IDLE;
						end
					end
				end

				// clock stays stopped while the host has no data
				S_WR_DATA: begin
					if (wr_valid && wr_ready) begin
						wr_ready   <= 1'b0;
						tx_start_q <= 1'b1;
						tx_word_q  <= wr_data;
						len_left   <= LEN_BITS'(len_left - 1'b1);
					end
					if (tx.done) begin
						if (len_left != '0) begin
							wr_ready <= 1'b1;
						end else begin
							flash_cs_n <= 1'b1;
							state      <= S_IDLE;
						end
					end
				end

				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_cs_init: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		(state inside {S_INIT, S_RESET, S_AFTER_RESET}) |-> flash_cs_n)
		else $error("flash_cmd_seq: chip select active during power-up");

	// both data lines share one gated clock
	a_one_shifter: assert property (@(posedge serial_clk_raw) disable iff (in_rst)
		!(tx.busy && rx.busy))
		else $error("flash_cmd_seq: both shifters busy");

endmodule

// ==== rtl/flash_serial.sv ====
`timescale 1ns/1ps

module flash_serial
	import flash_pkg::*;
(
	input  logic        serial_clk_raw,
	input  logic        in_rst,

	// host request
	input  logic        req_valid,
	output logic        req_ready,
	input  logic        req_read,
	input  flash_addr_t req_addr,
	input  flash_len_t  req_len,

	// host write data
	input  logic        wr_valid,
	output logic        wr_ready,
	input  flash_word_t wr_data,

	// host read data
	output logic        rd_valid,
	input  logic        rd_ready,
	output flash_word_t rd_data,

	// flash pins
	output logic        flash_rst_n,
	output logic        flash_clk,
	output logic        flash_cs_n,
	output logic        flash_wp_n,
	output logic        flash_mosi,
	input  logic        flash_miso
);

	logic flash_clk_en;
	logic clk_en_q;

	flash_shift_if tx_if ();
	flash_shift_if rx_if ();

	// ----------------------------------------------------------
	// gated flash clock
	// ----------------------------------------------------------
	// enable changes only while the raw clock is low, idles high
	always_ff @(negedge serial_clk_raw or posedge in_rst) begin
		if (in_rst) begin
			clk_en_q <= 1'b0;
		end else begin
			clk_en_q <= flash_clk_en;
		end
	end

	assign flash_clk = serial_clk_raw | ~clk_en_q;

	flash_cmd_seq u_cmd_seq (
		.serial_clk_raw (serial_clk_raw),
		.in_rst         (in_rst),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_read       (req_read),
		.req_addr       (req_addr),
		.req_len        (req_len),
		.wr_valid       (wr_valid),
		.wr_ready       (wr_ready),
		.wr_data        (wr_data),
		.rd_valid       (rd_valid),
		.rd_ready       (rd_ready),
		.rd_data        (rd_data),
		.tx             (tx_if.sequencer),
		.rx             (rx_if.sequencer),
		.flash_rst_n    (flash_rst_n),
		.flash_clk_en   (flash_clk_en),
		.flash_cs_n     (flash_cs_n),
		.flash_wp_n     (flash_wp_n)
	);

	flash_shift_out u_shift_out (
		.serial_clk_raw (serial_clk_raw),
		.in_rst         (in_rst),
		.shift          (tx_if.out_shifter),
		.mosi           (flash_mosi)
	);

	flash_shift_in u_shift_in (
		.serial_clk_raw (serial_clk_raw),
		.in_rst         (in_rst),
		.shift          (rx_if.in_shifter),
		.miso           (flash_miso)
	);

endmodule

// ==== sim/flash_spi_model.sv ====
`timescale 1ns/1ps

module flash_spi_model
	import flash_pkg::*;
#(
	parameter flash_word_t STATUS_INIT = 8'h9e
) (
	input  logic serial_clk_raw,
	input  logic flash_rst_n,
	input  logic flash_clk,
	input  logic flash_cs_n,
	input  logic flash_wp_n,
	input  logic flash_mosi,
	output logic flash_miso,
	output logic error_seen
);

	flash_word_t mem [0 : 65535];
	// one entry per command word seen
	flash_word_t cmd_log [0 : 63];
	int          cmd_count;
	flash_word_t status_reg;
	flash_word_t status_written;
	int          status_wr_count;

	// frame state
	logic        wel;
	logic        rd_phase;
	flash_word_t cmd;
	flash_word_t in_sreg;
	flash_word_t out_sreg;
	int          in_bits;
	int          out_bits;
	int          byte_idx;
	flash_addr_t wr_addr;
	flash_addr_t rd_ptr;

	task automatic protocol_error(input string what);
		$display("flash model: %s at %0t ns", what, $time);
		error_seen = 1'b1;
	endtask

	initial begin
		// fill depends on both address bytes
		for (int a = 0; a < 65536; a++) begin
			mem[a] = flash_word_t'(a[15:8] ^ a[7:0] ^ 8'h3c);
		end
		cmd_count       = 0;
		status_reg      = STATUS_INIT;
		status_written  = '0;
		status_wr_count = 0;
		wel             = 1'b0;
		rd_phase        = 1'b0;
		cmd             = '0;
		in_sreg         = '0;
		out_sreg        = '0;
		in_bits         = 0;
		out_bits        = 0;
		byte_idx        = 0;
		wr_addr         = '0;
		rd_ptr          = '0;
		flash_miso      = 1'b0;
		error_seen      = 1'b0;
	end

	// ------------------------------------------------------------
	// decode of one received word
	// ------------------------------------------------------------
	task automatic take_byte(input flash_word_t b);
		if (byte_idx == 0) begin
			cmd = b;
			if (cmd_count < 64) begin
				cmd_log[cmd_count] = b;
			end
			cmd_count++;
			case (b)
				CMD_WRITE_ENABLE:  wel = 1'b1;
				CMD_WRITE_DISABLE: wel = 1'b0;
				CMD_READ_STATUS:   rd_phase = 1'b1;
				CMD_READ:          ;
				CMD_WRITE, CMD_WRITE_STATUS: begin
					if (!wel) begin
						protocol_error("write command without a preceding write enable");
					end
				end
				default: protocol_error("unknown command code");
			endcase
		end else if (cmd == CMD_READ) begin
			// address high word first, data phase after it
			if (byte_idx <= ADDR_WORDS) begin
				wr_addr = flash_addr_t'({wr_addr, b});
				if (byte_idx == ADDR_WORDS) begin
					rd_ptr   = wr_addr;
					rd_phase = 1'b1;
				end
			end
		end else if (cmd == CMD_WRITE) begin
			if (byte_idx <= ADDR_WORDS) begin
				wr_addr = flash_addr_t'({wr_addr, b});
			end else begin
				if (flash_wp_n) begin
					protocol_error("data written while write protect is high");
				end
				mem[wr_addr] = b;
				wr_addr++;
			end
		end else if (cmd == CMD_WRITE_STATUS && byte_idx == 1) begin
			if (flash_wp_n) begin
				protocol_error("status written while write protect is high");
			end
			status_reg     = b;
			status_written = b;
			status_wr_count++;
		end else if (cmd != CMD_READ_STATUS) begin
			protocol_error("extra word after a command that takes none");
		end
	endtask

	// ------------------------------------------------------------
	// frames and bit clock
	// ------------------------------------------------------------
	// flash reset clears the write enable latch
	always @(negedge flash_rst_n) begin
		wel = 1'b0;
	end

	always @(negedge flash_cs_n) begin
		if (!flash_rst_n) begin
			protocol_error("chip select went low while the flash is in reset");
		end
		in_bits  = 0;
		out_bits = 0;
		byte_idx = 0;
		rd_phase = 1'b0;
	end

	always @(posedge flash_cs_n) begin
		if (in_bits != 0) begin
			protocol_error("chip select rose in the middle of a word");
		end
		// write enable is used up by a write frame
		if (byte_idx > 0 && (cmd == CMD_WRITE || cmd == CMD_WRITE_STATUS)) begin
			wel = 1'b0;
		end
		rd_phase = 1'b0;
	end

	// real rising edges come with the raw clock, gate glitches do not
	always @(posedge flash_clk) begin
		if (serial_clk_raw && !flash_cs_n) begin
			in_sreg = {in_sreg[WORD_BITS - 2 : 0], flash_mosi};
			if (in_bits == WORD_BITS - 1) begin
				in_bits = 0;
				take_byte(in_sreg);
				byte_idx++;
			end else begin
				in_bits++;
			end
		end
	end

	// zero width low pulses are ignored
	always @(negedge flash_clk) begin
		#1;
		if (flash_clk == 1'b0) begin
			if (flash_cs_n) begin
				protocol_error("flash clock running while chip select is high");
			end else if (rd_phase) begin
				if (out_bits == 0) begin
					if (cmd == CMD_READ_STATUS) begin
						out_sreg = status_reg;
					end else begin
						out_sreg = mem[rd_ptr];
						rd_ptr++;
					end
				end
				flash_miso = out_sreg[WORD_BITS - 1];
				out_sreg   = out_sreg << 1;
				out_bits   = (out_bits == WORD_BITS - 1) ? 0 : out_bits + 1;
			end
		end
	end

endmodule

// ==== sim/flash_serial_tb.sv ====
`timescale 1ns/1ps

module flash_serial_tb
	import flash_pkg::*;
();

	localparam int          TIMEOUT_CYCLES   = 3000;
	localparam int          INIT_WORDS       = 8;
	localparam flash_addr_t INIT_ADDR        = 16'h0120;
	localparam int          REQ_BASE         = 'h10;
	localparam int          MAX_REQS         = 8;
	localparam flash_word_t MODEL_STATUS     = 8'h9e;
	localparam int          POWER_UP_CYCLES  = WAIT_INIT + WAIT_RESET + WAIT_AFTER_RESET;
	localparam int          MIN_READ_LATENCY = WORD_BITS * (1 + ADDR_WORDS + 1);

	logic        serial_clk_raw;
	logic        in_rst;
	logic        req_valid;
	logic        req_ready;
	logic        req_read;
	flash_addr_t req_addr;
	flash_len_t  req_len;
	logic        wr_valid;
	logic        wr_ready;
	flash_word_t wr_data;
	logic        rd_valid;
	logic        rd_ready;
	flash_word_t rd_data;
	logic        flash_rst_n;
	logic        flash_clk;
	logic        flash_cs_n;
	logic        flash_wp_n;
	logic        flash_mosi;
	logic        flash_miso;
	logic        model_error;

	// init contents, request list, write data and expected read words
	logic [15:0] pat [0 : 127];
	logic [31:0] lfsr;
	int          rst_pulses;

	flash_serial u_flash_serial (.*);

	flash_spi_model #(.STATUS_INIT(MODEL_STATUS)) u_model (
		.serial_clk_raw (serial_clk_raw),
		.flash_rst_n    (flash_rst_n),
		.flash_clk      (flash_clk),
		.flash_cs_n     (flash_cs_n),
		.flash_wp_n     (flash_wp_n),
		.flash_mosi     (flash_mosi),
		.flash_miso     (flash_miso),
		.error_seen     (model_error)
	);

	initial begin
		serial_clk_raw = 1'b0;
		forever #50 serial_clk_raw = ~serial_clk_raw;
	end

	always @(negedge flash_rst_n) begin
		rst_pulses++;
	end

	always @(posedge model_error) begin
		$display("flash model saw a protocol error");
		$display("sim failed");
		$fatal(1, "protocol error");
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b    = lfsr[0];
	endtask

	// bits 7, 1, 0 survive the unlock
	function automatic flash_word_t kept_status_bits(input flash_word_t s);
		return {s[7], 5'b00000, s[1:0]};
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns: %s never came", $time, what);
		$display("sim failed");
		$fatal(1, "timeout");
	endtask

	task automatic compare_word(input string name, input flash_word_t got, input flash_word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic compare_status(input string name, input flash_word_t got, input flash_word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	task automatic watch_power_up();
		int cycles;
		cycles = 0;
		while (!req_ready) begin
			compare_flag("wr_ready", wr_ready, 1'b0);
			compare_flag("rd_valid", rd_valid, 1'b0);
			compare_flag("flash_cs_n", flash_cs_n, 1'b1);
			compare_flag("flash_wp_n", flash_wp_n, 1'b1);
			@(negedge serial_clk_raw);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("req_ready after power-up");
		end
		compare_count("power-up cycles", cycles, POWER_UP_CYCLES);
		compare_count("flash_rst_n pulses", rst_pulses, 1);
		compare_flag("flash_rst_n", flash_rst_n, 1'b1);
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (!req_ready || !flash_cs_n) begin
			@(negedge serial_clk_raw);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("end of request");
		end
	endtask

	// ready is registered, so the value seen here holds to the next rising edge
	task automatic send_request(input logic read, input flash_addr_t addr, input flash_len_t len);
		int cycles;
		cycles    = 0;
		req_read  = read;
		req_addr  = addr;
		req_len   = len;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(negedge serial_clk_raw);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("req_ready");
		end
		@(negedge serial_clk_raw);
		req_valid = 1'b0;
	endtask

	task automatic write_burst(input int off, input int len);
		int   idx;
		int   cycles;
		logic xfer;
		logic b0;
		logic b1;
		idx    = 0;
		cycles = 0;
		xfer   = 1'b0;
		while (idx < len) begin
			@(negedge serial_clk_raw);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("wr_ready");
			if (xfer) begin
				idx++;
				cycles = 0;
			end
			if (idx < len) begin
				take_bit(b0);
				take_bit(b1);
				wr_valid = b0 | b1;
				wr_data  = pat[off + idx][7:0];
			end else begin
				wr_valid = 1'b0;
			end
			xfer = wr_valid && wr_ready;
		end
	endtask

	task automatic read_burst(input int off, input int len);
		int   idx;
		int   cycles;
		int   latency;
		logic b0;
		logic b1;
		idx     = 0;
		cycles  = 0;
		latency = 0;
		while (idx < len) begin
			@(negedge serial_clk_raw);
			cycles++;
			latency++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("rd_valid");
			take_bit(b0);
			take_bit(b1);
			rd_ready = b0 | b1;
			if (rd_valid && rd_ready) begin
				if (idx == 0 && latency < MIN_READ_LATENCY) begin
					$display("first read word came after only %0d cycles", latency);
					$display("sim failed");
					$fatal(1, "read latency too short");
				end
				compare_word("rd_data", rd_data, pat[off + idx][7:0]);
				idx++;
				cycles = 0;
			end
		end
		@(negedge serial_clk_raw);
		rd_ready = 1'b0;
	endtask

	// commands the model logged for one request
	task automatic verify_command_log(input logic read, input logic first_write, input int start);
		if (read) begin
			compare_word("command", u_model.cmd_log[start], CMD_READ);
			compare_count("commands in read", u_model.cmd_count - start, 1);
		end else if (first_write) begin
			compare_word("command 0", u_model.cmd_log[start], CMD_WRITE_ENABLE);
			compare_word("command 1", u_model.cmd_log[start + 1], CMD_READ_STATUS);
			compare_word("command 2", u_model.cmd_log[start + 2], CMD_WRITE_STATUS);
			compare_word("command 3", u_model.cmd_log[start + 3], CMD_WRITE_ENABLE);
			compare_word("command 4", u_model.cmd_log[start + 4], CMD_WRITE);
			compare_count("commands in first write", u_model.cmd_count - start, 5);
			compare_status("status written", u_model.status_written,
				kept_status_bits(MODEL_STATUS));
		end else begin
			compare_word("command 0", u_model.cmd_log[start], CMD_WRITE_ENABLE);
			compare_word("command 1", u_model.cmd_log[start + 1], CMD_WRITE);
			compare_count("commands in write", u_model.cmd_count - start, 2);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int   base;
		int   log_start;
		int   writes_done;
		logic is_read;
		in_rst      = 1'b1;
		req_valid   = 1'b0;
		req_read    = 1'b0;
		req_addr    = '0;
		req_len     = '0;
		wr_valid    = 1'b0;
		wr_data     = '0;
		rd_ready    = 1'b0;
		lfsr        = 32'hdb35_57ee;
		rst_pulses  = 0;
		writes_done = 0;
		$readmemh("sim/flash_patterns.txt", pat);

		repeat (3) @(posedge serial_clk_raw);
		@(negedge serial_clk_raw);
		// overrides the model fill, which ran at time zero
		for (int i = 0; i < INIT_WORDS; i++) begin
			u_model.mem[INIT_ADDR + i] = pat[i][7:0];
		end
		in_rst = 1'b0;
		watch_power_up();

		for (int r = 0; r < MAX_REQS; r++) begin
			base = REQ_BASE + 4 * r;
			if (pat[base] == 16'h00ff) break;
			is_read   = (pat[base] == 16'h0000);
			log_start = u_model.cmd_count;
			send_request(is_read, flash_addr_t'(pat[base + 1]), flash_len_t'(pat[base + 2]));
			if (is_read) begin
				read_burst(int'(pat[base + 3]), int'(pat[base + 2]));
			end else begin
				write_burst(int'(pat[base + 3]), int'(pat[base + 2]));
			end
			wait_idle();
			verify_command_log(is_read, !is_read && writes_done == 0, log_start);
			if (!is_read) writes_done++;
		end
		compare_count("status writes", u_model.status_wr_count, 1);
		// no second flash reset after power-up
		compare_count("flash_rst_n pulses", rst_pulses, 1);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== flash_serial.f ====
rtl/flash_pkg.sv
rtl/flash_shift_if.sv
rtl/flash_shift_out.sv
rtl/flash_shift_in.sv
rtl/flash_cmd_seq.sv
rtl/flash_serial.sv
sim/flash_spi_model.sv
sim/flash_serial_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the flash controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module flash_serial_tb \
	-f flash_serial.f -o sim_flash > build.log 2>&1 \
	&& ./obj_dir/sim_flash > sim.log 2>&1 \
	|| echo "build or simulation stopped early, see build.log" >> sim.log
cat sim.log
# the log decides the result
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// ==== sim/flash_patterns.txt ====
// one 16-bit hex word per entry, low byte is the flash word
// @00 flash contents from address 0120, @10 requests of four words:
// kind (0 read, 1 write, ff end), address, length, data offset
@00
00c3 0017 00a5 005e 0091 003c 00e8 0042
@10
0000 0120 0008 0040
0001 0200 0004 0048
0001 0204 0003 004c
0000 0200 0007 0050
0000 0124 0002 0044
00ff 0000 0000 0000
// @40 expected initial contents, @48 and @4c write data
@40
00c3 0017 00a5 005e 0091 003c 00e8 0042
00d1 0002 00ff 0080
0055 00aa 0019
// @50 expected words of the read back at 0200
@50
00d1 0002 00ff 0080 0055 00aa 0019
